// ==== cong_man_pkg.sv ====
////////////////////////////////////////
// Four egress ports with four queues each, 8-byte words, lengths up to 2047
// Queue id is {port, queue index}; counter address is {queue id, drop type}
////////////////////////////////////////
package cong_man_pkg;

    // Queue geometry
    localparam int NUM_EGR_PORTS   = 4;
    localparam int QUEUES_PER_PORT = 4;
    localparam int NUM_QUEUES      = NUM_EGR_PORTS * QUEUES_PER_PORT;
    localparam int PORT_WIDTH      = $clog2(NUM_EGR_PORTS);
    localparam int QIDX_WIDTH      = $clog2(QUEUES_PER_PORT);
    localparam int QUEUE_ID_WIDTH  = $clog2(NUM_QUEUES);
    localparam int PRIO_WIDTH      = 3;

    // Word and length sizes
    localparam int DATA_BYTES = 8;
    localparam int DATA_WIDTH = DATA_BYTES * 8;
    localparam int LEN_WIDTH  = 11;
    localparam int OCC_WIDTH  = 16;

    // Drop counters
    localparam int CNTR_WIDTH      = 32;
    localparam int NUM_DROP_TYPES  = 2;
    localparam int NUM_CNTRS       = NUM_QUEUES * NUM_DROP_TYPES;
    localparam int CNTR_ADDR_WIDTH = $clog2(NUM_CNTRS);

    typedef logic [QUEUE_ID_WIDTH-1:0] queue_id_t;

    typedef enum logic {
        POLICER_DROP,
        QUEUE_FULL_DROP
    } drop_type_t;

    typedef enum logic [1:0] {
        READ,
        READ_AND_CLEAR,
        CLEAR_ALL
    } cntr_op_t;

    typedef enum logic {
        INIT,
        ACTIVE
    } counter_state_t;

    ////////////////////////////////////////
    // Sideband and strobe structs

    // Valid on the first word of a packet only
    typedef struct packed {
        logic [PORT_WIDTH-1:0] egress_port;
        logic [PRIO_WIDTH-1:0] prio;
        logic                  policer_mark;
        logic [LEN_WIDTH-1:0]  byte_length;
    } pkt_meta_t;

    typedef struct packed {
        queue_id_t            queue;
        logic [LEN_WIDTH-1:0] byte_length;
    } out_meta_t;

    typedef struct packed {
        logic                 valid;
        queue_id_t            queue;
        logic [OCC_WIDTH-1:0] threshold;
    } thresh_wr_t;

    // Also used for the admit update into the occupancy table
    typedef struct packed {
        logic                 valid;
        queue_id_t            queue;
        logic [LEN_WIDTH-1:0] bytes;
    } deq_t;

    typedef struct packed {
        logic       valid;
        queue_id_t  queue;
        drop_type_t drop_type;
    } drop_evt_t;

    typedef struct packed {
        logic       valid;
        cntr_op_t   op;
        queue_id_t  queue;
        drop_type_t drop_type;
    } cntr_req_t;

    typedef struct packed {
        logic                  valid;
        logic [CNTR_WIDTH-1:0] value;
    } cntr_rsp_t;

endpackage

// ==== cong_man_thresh_table.sv ====
////////////////////////////////////////
// Thresholds reset to all ones; a write is seen from the next cycle
////////////////////////////////////////
`timescale 1ns/1ps

module cong_man_thresh_table (
    input  logic                                  counter_access,
    input  logic                                  rst_n,
    input  cong_man_pkg::thresh_wr_t              thresh_wr,
    input  cong_man_pkg::queue_id_t               rd_queue,
    output logic [cong_man_pkg::OCC_WIDTH-1:0]    rd_threshold
);

    import cong_man_pkg::*;

    logic [OCC_WIDTH-1:0] thresholds [NUM_QUEUES];

    always_ff @(posedge counter_access) begin
        if (!rst_n) begin
            thresholds <= '{default: '1};
        end else if (thresh_wr.valid) begin
            thresholds[thresh_wr.queue] <= thresh_wr.threshold;
        end
    end

    // Lookup for the queue under decision
    assign rd_threshold = thresholds[rd_queue];

endmodule

// ==== cong_man_occupancy.sv ====
////////////////////////////////////////
// Byte count per queue; dequeue saturates at zero
// Admission must keep every count below 2^16
////////////////////////////////////////
`timescale 1ns/1ps

module cong_man_occupancy (
    input  logic                                  counter_access,
    input  logic                                  rst_n,
    input  cong_man_pkg::deq_t                    admit,
    input  cong_man_pkg::deq_t                    deq,
    input  cong_man_pkg::queue_id_t               rd_queue,
    output logic [cong_man_pkg::OCC_WIDTH-1:0]    rd_bytes
);

    import cong_man_pkg::*;

    logic [OCC_WIDTH-1:0] counts      [NUM_QUEUES];
    logic [OCC_WIDTH-1:0] counts_next [NUM_QUEUES];
    logic [OCC_WIDTH:0]   admit_ext;
    logic [OCC_WIDTH:0]   deq_ext;

    assign admit_ext = {{(OCC_WIDTH + 1 - LEN_WIDTH){1'b0}}, admit.bytes};
    assign deq_ext   = {{(OCC_WIDTH + 1 - LEN_WIDTH){1'b0}}, deq.bytes};

    // Admit and dequeue both apply when they hit one queue together
    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
        logic [OCC_WIDTH:0] sum;
        logic [OCC_WIDTH:0] sub;
        logic [OCC_WIDTH:0] diff;

        assign sum  = {1'b0, counts[q]} +
                      ((admit.valid && admit.queue == queue_id_t'(q)) ? admit_ext : '0);
        assign sub  = (deq.valid && deq.queue == queue_id_t'(q)) ? deq_ext : '0;
        assign diff = sum - sub;

        // Clamp at zero on over-dequeue
        assign counts_next[q] = (sum > sub) ? diff[OCC_WIDTH-1:0] : '0;
    end

    always_ff @(posedge counter_access) begin
        if (!rst_n) begin
            counts <= '{default: '0};
        end else begin
            counts <= counts_next;
        end
    end

    assign rd_bytes = counts[rd_queue];

    // The queue-full check upstream keeps counts in range
    a_admit_no_wrap: assert property (
        @(posedge counter_access) disable iff (!rst_n)
        admit.valid |-> ({1'b0, counts[admit.queue]} + admit_ext) <= {1'b0, {OCC_WIDTH{1'b1}}}
    );

endmodule

// ==== cong_man_admission.sv ====
////////////////////////////////////////
// No back-pressure; in_meta is only looked at on the first word of a packet
// Drop is decided once per packet and applied to all of its words
////////////////////////////////////////
`timescale 1ns/1ps

module cong_man_admission (
    input  logic                                  counter_access,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic                                  in_last,
    input  logic [cong_man_pkg::DATA_WIDTH-1:0]   in_data,
    input  cong_man_pkg::pkt_meta_t               in_meta,
    output logic                                  out_valid,
    output logic                                  out_last,
    output logic [cong_man_pkg::DATA_WIDTH-1:0]   out_data,
    output cong_man_pkg::out_meta_t               out_meta,
    output cong_man_pkg::queue_id_t               lookup_queue,
    input  logic [cong_man_pkg::OCC_WIDTH-1:0]    occupancy,
    input  logic [cong_man_pkg::OCC_WIDTH-1:0]    threshold,
    output cong_man_pkg::deq_t                    admit,
    output cong_man_pkg::drop_evt_t               drop_evt
);

    import cong_man_pkg::*;

    typedef struct packed {
        logic                  valid;
        logic                  first;
        logic                  last;
        logic                  police;
        queue_id_t             queue;
        logic [LEN_WIDTH-1:0]  len;
        logic [DATA_WIDTH-1:0] data;
    } stage_t;

    // Prio 7, 6, 5 to queues 3, 2, 1; everything else to queue 0
    function automatic logic [QIDX_WIDTH-1:0] prio_to_queue(input logic [PRIO_WIDTH-1:0] prio);
        case (prio)
            3'd7:    return 2'd3;
            3'd6:    return 2'd2;
            3'd5:    return 2'd1;
            default: return 2'd0;
        endcase
    endfunction

    stage_t             s0;
    logic               in_sop;
    logic               pkt_drop;
    logic               out_eop_q;
    logic               drop_open;
    logic               new_pkt;
    logic               full;
    logic               drop_decision;
    logic               drop_now;
    logic [OCC_WIDTH:0] occ_plus_len;

    ////////////////////////////////////////
    // Stage 0

    always_ff @(posedge counter_access) begin
        if (!rst_n) begin
            in_sop   <= 1'b1;
            s0.valid <= 1'b0;
            s0.first <= 1'b0;
        end else begin
            s0.valid <= in_valid;
            s0.first <= in_valid && in_sop;
            s0.last  <= in_last;
            s0.data  <= in_data;
            if (in_valid) begin
                in_sop <= in_last;
            end
            // Packet fields held for the rest of the packet
            if (in_valid && in_sop) begin
                s0.queue  <= {in_meta.egress_port, prio_to_queue(in_meta.prio)};
                s0.len    <= in_meta.byte_length;
                s0.police <= in_meta.policer_mark && (in_meta.prio < 3'd6);
            end
        end
    end

    ////////////////////////////////////////
    // Stage 1 decision

    assign lookup_queue = s0.queue;
    assign new_pkt      = s0.valid && s0.first;

    assign occ_plus_len  = {1'b0, occupancy} + {{(OCC_WIDTH + 1 - LEN_WIDTH){1'b0}}, s0.len};
    assign full          = occ_plus_len > {1'b0, threshold};
    assign drop_decision = s0.police || full;
    assign drop_now      = s0.first ? drop_decision : pkt_drop;

    // Occupancy update lands on the same edge as the output register
    assign admit = '{valid: new_pkt && !drop_decision, queue: s0.queue, bytes: s0.len};

    always_ff @(posedge counter_access) begin
        if (!rst_n) begin
            out_valid      <= 1'b0;
            out_last       <= 1'b0;
            out_eop_q      <= 1'b0;
            pkt_drop       <= 1'b0;
            drop_evt.valid <= 1'b0;
        end else begin
            out_valid <= s0.valid && !drop_now;
            out_last  <= s0.valid && s0.last && !drop_now;
            out_eop_q <= s0.valid && s0.last;
            out_data  <= s0.data;
            out_meta  <= '{queue: s0.queue, byte_length: s0.len};

            drop_evt.valid     <= new_pkt && drop_decision;
            drop_evt.queue     <= s0.queue;
            drop_evt.drop_type <= s0.police ? POLICER_DROP : QUEUE_FULL_DROP;

            if (new_pkt) begin
                pkt_drop <= drop_decision;
            end
        end
    end

    // Open from a drop event until the dropped packet's last word has passed
    always_ff @(posedge counter_access) begin
        if (!rst_n) begin
            drop_open <= 1'b0;
        end else if (drop_evt.valid && !out_eop_q) begin
            drop_open <= 1'b1;
        end else if (out_eop_q) begin
            drop_open <= 1'b0;
        end
    end

    // Nothing of a dropped packet reaches the output, up to its last word
    a_drop_suppresses_pkt: assert property (
        @(posedge counter_access) disable iff (!rst_n)
        (drop_evt.valid || drop_open) |-> !out_valid
    );

endmodule

// ==== cong_man_drop_counters.sv ====
////////////////////////////////////////
// Drop events during INIT are not counted
// Requests wait while cntr_ready is low
////////////////////////////////////////
`timescale 1ns/1ps

module cong_man_drop_counters (
    input  logic                    counter_access,
    input  logic                    rst_n,
    input  cong_man_pkg::drop_evt_t drop_evt,
    input  cong_man_pkg::cntr_req_t cntr_req,
    output logic                    cntr_ready,
    output cong_man_pkg::cntr_rsp_t cntr_rsp
);

    import cong_man_pkg::*;

    logic [CNTR_WIDTH-1:0]      cntr_mem [NUM_CNTRS];
    counter_state_t             state;
    logic [CNTR_ADDR_WIDTH-1:0] sweep_addr;
    logic [CNTR_ADDR_WIDTH-1:0] evt_addr;
    logic [CNTR_ADDR_WIDTH-1:0] req_addr;
    logic                       req_accept;
    logic                       inc_pending;
    logic [CNTR_ADDR_WIDTH-1:0] inc_addr;
    logic [CNTR_WIDTH-1:0]      inc_base;
    logic [CNTR_WIDTH-1:0]      inc_sum;
    logic                       rsp_valid;
    logic [CNTR_WIDTH-1:0]      rsp_value;

    assign evt_addr = {drop_evt.queue, drop_evt.drop_type};
    assign req_addr = {cntr_req.queue, cntr_req.drop_type};
    assign inc_sum  = inc_base + CNTR_WIDTH'(1);

    // Requests never overlap an increment, so the write port is free
    assign cntr_ready = (state == ACTIVE) && !drop_evt.valid && !inc_pending;
    assign req_accept = cntr_req.valid && cntr_ready;

    assign cntr_rsp = '{valid: rsp_valid, value: rsp_value};

    ////////////////////////////////////////
    // Control FSM

    always_ff @(posedge counter_access) begin
        if (!rst_n) begin
            state       <= INIT;
            sweep_addr  <= '0;
            inc_pending <= 1'b0;
            rsp_valid   <= 1'b0;
        end else begin
            inc_pending <= drop_evt.valid && (state == ACTIVE);
            rsp_valid   <= req_accept;
            case (state)
                INIT: begin
                    sweep_addr <= sweep_addr + 1'b1;
                    if (sweep_addr == CNTR_ADDR_WIDTH'(NUM_CNTRS - 1)) begin
                        state <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (req_accept && cntr_req.op == CLEAR_ALL) begin
                        state      <= INIT;
                        sweep_addr <= '0;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    ////////////////////////////////////////
    // Counter memory

    always_ff @(posedge counter_access) begin
        // Read half of the increment, forwarding a write still in flight
        inc_addr <= evt_addr;
        if (inc_pending && inc_addr == evt_addr) begin
            inc_base <= inc_sum;
        end else begin
            inc_base <= cntr_mem[evt_addr];
        end

        // Value before any clear
        if (cntr_req.op == CLEAR_ALL) begin
            rsp_value <= '0;
        end else begin
            rsp_value <= cntr_mem[req_addr];
        end

        if (state == INIT) begin
            cntr_mem[sweep_addr] <= '0;
        end else if (inc_pending) begin
            cntr_mem[inc_addr] <= inc_sum;
        end else if (req_accept && cntr_req.op == READ_AND_CLEAR) begin
            cntr_mem[req_addr] <= '0;
        end
    end

    // CLEAR_ALL is held off while an increment is in flight
    a_no_inc_in_init: assert property (
        @(posedge counter_access) disable iff (!rst_n)
        inc_pending |-> state == ACTIVE
    );

endmodule

// ==== cong_man_top.sv ====
////////////////////////////////////////
// Word in at edge N leaves at edge N+2 when admitted
////////////////////////////////////////
`timescale 1ns/1ps

module cong_man_top (
    input  logic                                  counter_access,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic                                  in_last,
    input  logic [cong_man_pkg::DATA_WIDTH-1:0]   in_data,
    input  cong_man_pkg::pkt_meta_t               in_meta,
    output logic                                  out_valid,
    output logic                                  out_last,
    output logic [cong_man_pkg::DATA_WIDTH-1:0]   out_data,
    output cong_man_pkg::out_meta_t               out_meta,
    input  cong_man_pkg::thresh_wr_t              thresh_wr,
    input  cong_man_pkg::deq_t                    deq,
    input  cong_man_pkg::cntr_req_t               cntr_req,
    output logic                                  cntr_ready,
    output cong_man_pkg::cntr_rsp_t               cntr_rsp
);

    import cong_man_pkg::*;

    queue_id_t            lookup_queue;
    logic [OCC_WIDTH-1:0] occupancy;
    logic [OCC_WIDTH-1:0] threshold;
    deq_t                 admit;
    drop_evt_t            drop_evt;

    cong_man_admission u_admission (
        .counter_access (counter_access),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_last        (in_last),
        .in_data        (in_data),
        .in_meta        (in_meta),
        .out_valid      (out_valid),
        .out_last       (out_last),
        .out_data       (out_data),
        .out_meta       (out_meta),
        .lookup_queue   (lookup_queue),
        .occupancy      (occupancy),
        .threshold      (threshold),
        .admit          (admit),
        .drop_evt       (drop_evt)
    );

    // Both tables answer the same lookup
    cong_man_thresh_table u_thresh_table (
        .counter_access (counter_access),
        .rst_n          (rst_n),
        .thresh_wr      (thresh_wr),
        .rd_queue       (lookup_queue),
        .rd_threshold   (threshold)
    );

    cong_man_occupancy u_occupancy (
        .counter_access (counter_access),
        .rst_n          (rst_n),
        .admit          (admit),
        .deq            (deq),
        .rd_queue       (lookup_queue),
        .rd_bytes       (occupancy)
    );

    cong_man_drop_counters u_drop_counters (
        .counter_access (counter_access),
        .rst_n          (rst_n),
        .drop_evt       (drop_evt),
        .cntr_req       (cntr_req),
        .cntr_ready     (cntr_ready),
        .cntr_rsp       (cntr_rsp)
    );

endmodule

// ==== cong_man_tb.sv ====
////////////////////////////////////////
// Runs cong_man_trace.txt from the project root and stops at the first mismatch
// Counter requests wait for the packet pipeline to drain before they go out
////////////////////////////////////////
`timescale 1ns/1ps

module cong_man_tb;

    import cong_man_pkg::*;

    typedef struct packed {
        logic [7:0] kind;
        int         a0;
        int         a1;
        int         a2;
        int         a3;
        int         a4;
    } trace_cmd_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
        out_meta_t             meta;
        int                    cycle;
    } exp_word_t;

    logic                  counter_access;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_last;
    logic [DATA_WIDTH-1:0] in_data;
    pkt_meta_t             in_meta;
    logic                  out_valid;
    logic                  out_last;
    logic [DATA_WIDTH-1:0] out_data;
    out_meta_t             out_meta;
    thresh_wr_t            thresh_wr;
    deq_t                  deq;
    cntr_req_t             cntr_req;
    logic                  cntr_ready;
    cntr_rsp_t             cntr_rsp;

    trace_cmd_t  cmds[$];
    exp_word_t   exp_q[$];
    exp_word_t   next_exp;
    int          cyc;
    int          cycle_limit;
    int          total_words;
    logic [31:0] lfsr_state;

    // Reference model of thresholds, occupancy and drop counts
    int model_occ   [NUM_QUEUES];
    int model_thr   [NUM_QUEUES];
    int model_drops [NUM_QUEUES][NUM_DROP_TYPES];

    cong_man_top uut (.*);

    initial begin
        counter_access = 1'b0;
        forever #2 counter_access = ~counter_access;
    end

    ////////////////////////////////////////
    // Failure reporting and compare tasks

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        stop_on_error($sformatf("[FAIL] %0d ns: %s", $time, what));
    endtask

    task automatic check_word(input logic [DATA_WIDTH-1:0] got_data, input logic got_last,
                              input logic [DATA_WIDTH-1:0] exp_data, input logic exp_last);
        if (got_data !== exp_data || got_last !== exp_last) begin
            report_mismatch($sformatf("word %h last %b, expected %h last %b",
                                      got_data, got_last, exp_data, exp_last));
        end
    endtask

    task automatic check_meta(input out_meta_t got, input out_meta_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("out_meta queue %0d len %0d, expected queue %0d len %0d",
                                      got.queue, got.byte_length, exp.queue, exp.byte_length));
        end
    endtask

    task automatic check_cntr(input cntr_rsp_t got, input cntr_rsp_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("cntr_rsp valid %b value %0d, expected valid %b value %0d",
                                      got.valid, got.value, exp.valid, exp.value));
        end
    endtask

    task automatic verify_latency(input int got_cycle, input int exp_cycle);
        if (got_cycle != exp_cycle) begin
            report_mismatch($sformatf("word left in cycle %0d, expected cycle %0d",
                                      got_cycle, exp_cycle));
        end
    endtask

    // Starts at a negedge inside the sweep; ready must stay low for every counter
    task automatic measure_init_sweep();
        int low_cycles;
        low_cycles = 0;
        while (!cntr_ready) begin
            low_cycles++;
            @(negedge counter_access);
        end
        if (low_cycles != NUM_CNTRS) begin
            report_mismatch($sformatf("cntr_ready low for %0d cycles, expected %0d",
                                      low_cycles, NUM_CNTRS));
        end
    endtask

    ////////////////////////////////////////
    // Stimulus helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_random_word(output logic [DATA_WIDTH-1:0] word);
        word = '0;
        for (int b = 0; b < DATA_WIDTH; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word       = {word[DATA_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [QIDX_WIDTH-1:0] queue_index(input int prio);
        if (prio == 7) return 2'd3;
        if (prio == 6) return 2'd2;
        if (prio == 5) return 2'd1;
        return 2'd0;
    endfunction

    task automatic clear_strobes();
        in_valid        = 1'b0;
        in_last         = 1'b0;
        thresh_wr.valid = 1'b0;
        deq.valid       = 1'b0;
        cntr_req.valid  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge counter_access);
            #1;
            clear_strobes();
        end
    endtask

    task automatic load_trace();
        int         fd;
        int         c;
        int         got;
        int         a[5];
        logic [7:0] ch;
        trace_cmd_t cmd;
        fd = $fopen("cong_man_trace.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the trace file cong_man_trace.txt");
        end
        total_words = 0;
        c = $fgetc(fd);
        while (c != -1) begin
            ch = c[7:0];
            if (ch == "#") begin
                while (c != -1 && c != 10) begin
                    c = $fgetc(fd);
                end
            end else if (ch inside {"P", "D", "T", "C", "I"}) begin
                a = '{default: 0};
                case (ch)
                    "P": got = $fscanf(fd, "%d %d %d %d %d", a[0], a[1], a[2], a[3], a[4]) - 5;
                    "C": got = $fscanf(fd, "%d %d %d %d", a[0], a[1], a[2], a[3]) - 4;
                    "I": got = $fscanf(fd, "%d", a[0]) - 1;
                    default: got = $fscanf(fd, "%d %d", a[0], a[1]) - 2;
                endcase
                if (got != 0) begin
                    stop_on_error($sformatf("Trace command %c has missing fields", ch));
                end
                cmd = '{kind: ch, a0: a[0], a1: a[1], a2: a[2], a3: a[3], a4: a[4]};
                cmds.push_back(cmd);
                if (ch == "P") total_words += (a[3] + DATA_BYTES - 1) / DATA_BYTES;
                else if (ch == "I") total_words += a[0];
                else total_words += 1;
            end else if (!(ch inside {" ", "\t", "\r", "\n"})) begin
                stop_on_error($sformatf("Unknown trace command %c", ch));
            end
            if (c != -1) c = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = 4 * total_words + 200;
    endtask

    ////////////////////////////////////////
    // Trace commands

    task automatic send_packet(input trace_cmd_t cmd);
        pkt_meta_t             meta;
        queue_id_t             q;
        int                    outcome;
        int                    nwords;
        logic [DATA_WIDTH-1:0] word;
        exp_word_t             e;
        meta = '{egress_port: PORT_WIDTH'(cmd.a0), prio: PRIO_WIDTH'(cmd.a1),
                 policer_mark: cmd.a2[0], byte_length: LEN_WIDTH'(cmd.a3)};
        q = {meta.egress_port, queue_index(cmd.a1)};
        // 0 admit, 1 policer drop, 2 queue-full drop
        if (cmd.a2 != 0 && cmd.a1 < 6) outcome = 1;
        else if (model_occ[q] + cmd.a3 > model_thr[q]) outcome = 2;
        else outcome = 0;
        if (outcome != cmd.a4) begin
            stop_on_error($sformatf("Trace expects outcome %0d for queue %0d, model gives %0d",
                                    cmd.a4, q, outcome));
        end
        if (outcome == 0) model_occ[q] += cmd.a3;
        else model_drops[q][outcome-1]++;
        nwords = (cmd.a3 + DATA_BYTES - 1) / DATA_BYTES;
        for (int i = 0; i < nwords; i++) begin
            @(posedge counter_access);
            #1;
            clear_strobes();
            next_random_word(word);
            in_valid = 1'b1;
            in_last  = (i == nwords - 1);
            in_data  = word;
            in_meta  = meta;
            if (outcome == 0) begin
                e = '{data: word, last: in_last, meta: '{queue: q, byte_length: meta.byte_length},
                      cycle: cyc + 2};
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic apply_dequeue(input trace_cmd_t cmd);
        queue_id_t q;
        q = queue_id_t'(cmd.a0);
        @(posedge counter_access);
        #1;
        clear_strobes();
        deq = '{valid: 1'b1, queue: q, bytes: LEN_WIDTH'(cmd.a1)};
        model_occ[q] = (model_occ[q] > cmd.a1) ? model_occ[q] - cmd.a1 : 0;
    endtask

    task automatic write_threshold(input trace_cmd_t cmd);
        @(posedge counter_access);
        #1;
        clear_strobes();
        thresh_wr = '{valid: 1'b1, queue: queue_id_t'(cmd.a0), threshold: OCC_WIDTH'(cmd.a1)};
        model_thr[cmd.a0] = cmd.a1;
    endtask

    task automatic request_counter(input trace_cmd_t cmd);
        int expected;
        // Decision is two edges after a first word, the increment two more
        idle_cycles(4);
        if (cmd.a0 == 2) begin
            expected = 0;
            foreach (model_drops[q, t]) model_drops[q][t] = 0;
        end else begin
            expected = model_drops[cmd.a1][cmd.a2];
            if (cmd.a0 == 1) model_drops[cmd.a1][cmd.a2] = 0;
        end
        if (expected != cmd.a3) begin
            stop_on_error($sformatf("Trace expects counter %0d for queue %0d type %0d, model has %0d",
                                    cmd.a3, cmd.a1, cmd.a2, expected));
        end
        @(posedge counter_access);
        #1;
        clear_strobes();
        cntr_req = '{valid: 1'b1, op: cntr_op_t'(cmd.a0), queue: queue_id_t'(cmd.a1),
                     drop_type: drop_type_t'(cmd.a2)};
        @(negedge counter_access);
        while (!cntr_ready) @(negedge counter_access);
        @(posedge counter_access);
        #1;
        clear_strobes();
        @(negedge counter_access);
        check_cntr(cntr_rsp, '{valid: 1'b1, value: CNTR_WIDTH'(expected)});
        if (cmd.a0 == 2) measure_init_sweep();
    endtask

    ////////////////////////////////////////
    // Output monitor and timeout

    always @(negedge counter_access) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("Output word appeared while no admitted word was pending");
            end else begin
                next_exp = exp_q.pop_front();
                verify_latency(cyc, next_exp.cycle);
                check_word(out_data, out_last, next_exp.data, next_exp.last);
                check_meta(out_meta, next_exp.meta);
            end
        end
    end

    always @(posedge counter_access) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        in_data    = '0;
        in_meta    = '0;
        thresh_wr  = '0;
        deq        = '0;
        cntr_req   = '0;
        cyc        = 0;
        lfsr_state = 32'hcfa;
        foreach (model_occ[q]) begin
            model_occ[q] = 0;
            model_thr[q] = (1 << OCC_WIDTH) - 1;
        end
        foreach (model_drops[q, t]) model_drops[q][t] = 0;
        load_trace();

        repeat (10) @(posedge counter_access);
        #1;
        rst_n = 1'b1;
        @(negedge counter_access);
        measure_init_sweep();

        foreach (cmds[i]) begin
            case (cmds[i].kind)
                "P": send_packet(cmds[i]);
                "D": apply_dequeue(cmds[i]);
                "T": write_threshold(cmds[i]);
                "C": request_counter(cmds[i]);
                default: idle_cycles(cmds[i].a0);
            endcase
        end
        idle_cycles(4);

        if (exp_q.size() != 0) begin
            stop_on_error($sformatf("%0d admitted words never left the DUT", exp_q.size()));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== cong_man_trace.txt ====
# P port prio mark bytes outcome(0 admit, 1 policer, 2 full) | D queue bytes | T queue threshold
# C op(0 read, 1 read+clear, 2 clear all) queue type(0 policer, 1 full) expected | I cycles
T 5 100
P 0 7 0 24 0
P 1 5 0 64 0
P 1 5 0 40 2
P 1 5 0 36 0
P 2 3 1 16 1
P 2 6 1 16 0
P 3 7 1 9 0
P 1 0 1 8 1
P 1 5 0 8 2
I 3
C 0 5 1 2
C 0 8 0 1
D 5 60
P 1 5 0 40 0
D 3 100
T 3 16
P 0 7 0 24 2
P 0 7 0 16 0
C 1 5 1 2
C 0 5 1 0
C 0 4 0 1
C 0 3 1 1
C 2 0 0 0
C 0 3 1 0
P 2 4 1 8 1
C 0 8 0 1

// ==== list.f ====
cong_man_pkg.sv
cong_man_thresh_table.sv
cong_man_occupancy.sv
cong_man_admission.sv
cong_man_drop_counters.sv
cong_man_top.sv
cong_man_tb.sv

// ==== Makefile ====
SIM    = verilator
FLAGS  = --binary --timing --assert
TOP    = cong_man_tb
FLIST  = list.f
OBJDIR = obj_dir

BIN    = $(OBJDIR)/V$(TOP)
SRCS   = $(shell grep -v '^+' $(FLIST))

.PHONY: run clean

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
